//--- Bender.yml
package:
  name: stat_monitor

dependencies: {}

sources:
  # Package and interface first, then the blocks and the top level
  - logic/stat_pkg.sv
  - logic/stat_tap_if.sv
  - logic/tap_capture.sv
  - logic/port_counter_bank.sv
  - logic/count_readback_mux.sv
  - logic/stat_monitor_top.sv
  - target: test
    files:
      - tb/stat_monitor_tb.sv

//--- build.f
logic/stat_pkg.sv
logic/stat_tap_if.sv
logic/tap_capture.sv
logic/port_counter_bank.sv
logic/count_readback_mux.sv
logic/stat_monitor_top.sv
tb/stat_monitor_tb.sv

//--- logic/count_readback_mux.sv
module count_readback_mux (
  input  logic                                                             clk,
  input  logic                                                             rst_n,
  input  logic [stat_pkg::port_width-1:0]                                  port_select,
  input  logic [stat_pkg::port_count-1:0][stat_pkg::byte_count_width-1:0]  byte_counts,
  input  logic [stat_pkg::port_count-1:0][stat_pkg::frame_count_width-1:0] frame_counts,
  output logic [stat_pkg::byte_count_width-1:0]                            byte_count,
  output logic [stat_pkg::frame_count_width-1:0]                           frame_count
);

  // Stage 1 registers
  logic [stat_pkg::port_width-1:0]                                  sel_r;
  logic [stat_pkg::port_count-1:0][stat_pkg::byte_count_width-1:0]  byte_r;
  logic [stat_pkg::port_count-1:0][stat_pkg::frame_count_width-1:0] frame_r;

  // Stage 2 registers, one entry per cluster
  logic [stat_pkg::port_width-stat_pkg::last_sel_bits-1:0]             sel_rr;
  logic [stat_pkg::port_clusters-1:0][stat_pkg::byte_count_width-1:0]  byte_rr;
  logic [stat_pkg::port_clusters-1:0][stat_pkg::frame_count_width-1:0] frame_rr;

  logic [stat_pkg::last_sel_bits-1:0]                         lo_sel;

  assign lo_sel = sel_r[stat_pkg::last_sel_bits-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_r   <= '0;
      byte_r  <= '0;
      frame_r <= '0;
      sel_rr  <= '0;
    end else begin
      sel_r   <= port_select;
      byte_r  <= byte_counts;
      frame_r <= frame_counts;
      sel_rr  <= sel_r[stat_pkg::port_width-1:stat_pkg::last_sel_bits];  // Keeps the select in step with the data
    end
  end

  // First level, one port out of each cluster
  for (genvar c = 0; c < stat_pkg::port_clusters; c++) begin : g_cluster
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        byte_rr[c]  <= '0;
        frame_rr[c] <= '0;
      end else begin
        byte_rr[c]  <= byte_r[c*stat_pkg::ports_per_cluster + lo_sel];
        frame_rr[c] <= frame_r[c*stat_pkg::ports_per_cluster + lo_sel];
      end
    end
  end

  // Second level between clusters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_count  <= '0;
      frame_count <= '0;
    end else begin
      byte_count  <= byte_rr[sel_rr];
      frame_count <= frame_rr[sel_rr];
    end
  end

endmodule

//--- logic/port_counter_bank.sv
module port_counter_bank (
  input  logic                                                             clk,
  input  logic                                                             rst_n,
  stat_tap_if.counters                                                     tap,
  output logic [stat_pkg::port_count-1:0][stat_pkg::byte_count_width-1:0]  byte_counts,
  output logic [stat_pkg::port_count-1:0][stat_pkg::frame_count_width-1:0] frame_counts
);

  // Contribution of the current cycle per port, zero without a beat
  logic [stat_pkg::port_count-1:0][stat_pkg::byte_count_width-1:0]  byte_inc;
  logic [stat_pkg::port_count-1:0][stat_pkg::frame_count_width-1:0] frame_inc;

  always_comb begin
    byte_inc  = '0;
    frame_inc = '0;
    for (int p = 0; p < stat_pkg::port_count; p++) begin
      if (tap.beat[p]) begin
        byte_inc[p][stat_pkg::beat_bytes_width-1:0] = tap.beat_bytes[p];
        frame_inc[p][0] = tap.last[p];  // Frame ends on tlast
      end
    end
  end

  // Priority is hold, then clear, then count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_counts  <= '0;
      frame_counts <= '0;
    end else begin
      for (int p = 0; p < stat_pkg::port_count; p++) begin
        if (tap.hold[p]) begin
          byte_counts[p]  <= '0;
          frame_counts[p] <= '0;
        end else if (tap.clr[p]) begin
          // A beat in the clear cycle still counts
          byte_counts[p]  <= byte_inc[p];
          frame_counts[p] <= frame_inc[p];
        end else begin
          byte_counts[p]  <= byte_counts[p] + byte_inc[p];  // Wraps
          frame_counts[p] <= frame_counts[p] + frame_inc[p];
        end
      end
    end
  end

endmodule

//--- logic/stat_monitor_top.sv
module stat_monitor_top (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [stat_pkg::port_count-1:0]                          port_rst,
  input  logic [stat_pkg::port_count-1:0]                          port_clear,
  input  logic [stat_pkg::port_count-1:0][stat_pkg::keep_width-1:0] monitor_tkeep,
  input  logic [stat_pkg::port_count-1:0]                          monitor_tvalid,
  input  logic [stat_pkg::port_count-1:0]                          monitor_tready,
  input  logic [stat_pkg::port_count-1:0]                          monitor_tlast,
  input  logic [stat_pkg::port_width-1:0]                          port_select,
  output logic [stat_pkg::byte_count_width-1:0]                    byte_count,
  output logic [stat_pkg::frame_count_width-1:0]                   frame_count
);

  logic [stat_pkg::port_count-1:0][stat_pkg::byte_count_width-1:0]  byte_counts;
  logic [stat_pkg::port_count-1:0][stat_pkg::frame_count_width-1:0] frame_counts;

  stat_tap_if tap0 ();

  tap_capture capture0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .port_rst   (port_rst),
    .port_clear (port_clear),
    .tkeep      (monitor_tkeep),
    .tvalid     (monitor_tvalid),
    .tready     (monitor_tready),
    .tlast      (monitor_tlast),
    .tap        (tap0.capture)
  );

  port_counter_bank counters0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .tap          (tap0.counters),
    .byte_counts  (byte_counts),
    .frame_counts (frame_counts)
  );

  // Three cycles from select or count to the outputs
  count_readback_mux readback0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_select  (port_select),
    .byte_counts  (byte_counts),
    .frame_counts (frame_counts),
    .byte_count   (byte_count),
    .frame_count  (frame_count)
  );

endmodule

//--- logic/stat_pkg.sv
package stat_pkg;

  // Monitored stream ports
  localparam int port_count = 4;
  localparam int keep_width = 8;

  // One beat carries 0 to keep_width bytes
  localparam int beat_bytes_width = 4;

  localparam int byte_count_width  = 32;
  localparam int frame_count_width = 32;

  localparam int port_width = 2;  // Port select

  // Readback selection geometry
  localparam int port_clusters     = 2;
  localparam int ports_per_cluster = 2;
  localparam int last_sel_bits     = 1;  // Select bits inside a cluster

endpackage

//--- logic/stat_tap_if.sv
interface stat_tap_if;

  // Accepted beat strobe per port
  logic [stat_pkg::port_count-1:0] beat;

  // Popcount of the beat's tkeep
  logic [stat_pkg::port_count-1:0][stat_pkg::beat_bytes_width-1:0] beat_bytes;

  logic [stat_pkg::port_count-1:0] last;  // tlast of the beat
  logic [stat_pkg::port_count-1:0] clr;   // port_clear, aligned with beat
  logic [stat_pkg::port_count-1:0] hold;  // port_rst, aligned with beat

  modport capture (
    output beat,
    output beat_bytes,
    output last,
    output clr,
    output hold
  );

  modport counters (
    input beat,
    input beat_bytes,
    input last,
    input clr,
    input hold
  );

endinterface

//--- logic/tap_capture.sv
module tap_capture (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [stat_pkg::port_count-1:0]                          port_rst,
  input  logic [stat_pkg::port_count-1:0]                          port_clear,
  input  logic [stat_pkg::port_count-1:0][stat_pkg::keep_width-1:0] tkeep,
  input  logic [stat_pkg::port_count-1:0]                          tvalid,
  input  logic [stat_pkg::port_count-1:0]                          tready,
  input  logic [stat_pkg::port_count-1:0]                          tlast,
  stat_tap_if.capture                                              tap
);

  logic [stat_pkg::port_count-1:0][stat_pkg::keep_width-1:0] tkeep_r;

  function automatic logic [stat_pkg::beat_bytes_width-1:0] popcount(
    input logic [stat_pkg::keep_width-1:0] keep
  );
    logic [stat_pkg::beat_bytes_width-1:0] sum;
    sum = '0;
    for (int b = 0; b < stat_pkg::keep_width; b++) begin
      if (keep[b]) begin
        sum = sum + 1'b1;
      end
    end
    return sum;
  endfunction

  // Tap registers, one cycle of latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tkeep_r  <= '0;
      tap.beat <= '0;
      tap.last <= '0;
      tap.clr  <= '0;
      tap.hold <= '0;
    end else begin
      tkeep_r  <= tkeep;
      tap.beat <= tvalid & tready & ~port_rst;  // Held ports see no beats
      tap.last <= tlast;
      tap.clr  <= port_clear;
      tap.hold <= port_rst;
    end
  end

  // Byte count of the registered beat
  always_comb begin
    for (int p = 0; p < stat_pkg::port_count; p++) begin
      tap.beat_bytes[p] = popcount(tkeep_r[p]);
    end
  end

endmodule

//--- tb/stat_monitor_tb.sv
module stat_monitor_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                                     clk;
  logic                                                     rst_n;
  logic [stat_pkg::port_count-1:0]                          port_rst;
  logic [stat_pkg::port_count-1:0]                          port_clear;
  logic [stat_pkg::port_count-1:0][stat_pkg::keep_width-1:0] monitor_tkeep;
  logic [stat_pkg::port_count-1:0]                          monitor_tvalid;
  logic [stat_pkg::port_count-1:0]                          monitor_tready;
  logic [stat_pkg::port_count-1:0]                          monitor_tlast;
  logic [stat_pkg::port_width-1:0]                          port_select;
  logic [stat_pkg::byte_count_width-1:0]                    byte_count;
  logic [stat_pkg::frame_count_width-1:0]                   frame_count;

  // Levels that persist between commands
  logic [stat_pkg::port_count-1:0] rst_level;
  logic [stat_pkg::port_width-1:0] sel_level;

  // Parsed commands, six arguments each
  string op_q[$];
  int    arg_q[$];
  int    total_cycles;

  stat_monitor_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .port_rst       (port_rst),
    .port_clear     (port_clear),
    .monitor_tkeep  (monitor_tkeep),
    .monitor_tvalid (monitor_tvalid),
    .monitor_tready (monitor_tready),
    .monitor_tlast  (monitor_tlast),
    .port_select    (port_select),
    .byte_count     (byte_count),
    .frame_count    (frame_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // One clock of traffic on the ports in mask, the rest idle with random tkeep
  task automatic drive_cycle(input int mask, input int keep, input int valid, input int ready,
                             input int last, input int clr_port);
    logic [stat_pkg::port_count-1:0][stat_pkg::keep_width-1:0] keep_v;
    logic [stat_pkg::port_count-1:0]                          valid_v;
    logic [stat_pkg::port_count-1:0]                          ready_v;
    logic [stat_pkg::port_count-1:0]                          last_v;
    logic [stat_pkg::port_count-1:0]                          clr_v;
    logic [31:0]                                              rand_word;
    clr_v = '0;
    if (clr_port >= 0) begin
      clr_v[clr_port] = 1'b1;
    end
    for (int p = 0; p < stat_pkg::port_count; p++) begin
      rand_word  = $urandom;
      keep_v[p]  = mask[p] ? keep[stat_pkg::keep_width-1:0] : rand_word[stat_pkg::keep_width-1:0];
      valid_v[p] = mask[p] & valid[0];  // Unnamed ports never show tvalid
      ready_v[p] = mask[p] & ready[0];
      last_v[p]  = mask[p] & last[0];
    end
    @(posedge clk);
    monitor_tkeep  <= keep_v;
    monitor_tvalid <= valid_v;
    monitor_tready <= ready_v;
    monitor_tlast  <= last_v;
    port_clear     <= clr_v;
    port_rst       <= rst_level;
    port_select    <= sel_level;
  endtask

  // Select a port, let the pipeline settle, compare at the falling edge
  task automatic check_port(input int port, input int exp_bytes, input int exp_frames);
    sel_level = port[stat_pkg::port_width-1:0];
    repeat (6) drive_cycle(0, 0, 0, 0, 0, -1);
    @(negedge clk);
    assert (byte_count == exp_bytes && frame_count == exp_frames) else begin
      $display("Mismatch at %0d ns: port %0d reads %0d bytes and %0d frames, expected %0d and %0d",
               $time, port, byte_count, frame_count, exp_bytes, exp_frames);
      $display("Something failed");
      $fatal(1, "Stopping on the first error");
    end
  endtask

  initial begin
    int    fd;
    int    code;
    int    n_exp;
    int    a[6];
    string op;
    string rest;

    void'($urandom(32'h4202c44e));
    rst_n          = 1'b0;
    port_rst       = '0;
    port_clear     = '0;
    monitor_tkeep  = '0;
    monitor_tvalid = '0;
    monitor_tready = '0;
    monitor_tlast  = '0;
    port_select    = '0;
    rst_level      = '0;
    sel_level      = '0;
    total_cycles   = 0;

    fd = $fopen("tb/stat_tests.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the tests file tb/stat_tests.txt");
      $display("Something failed");
      $fatal(1, "No stimulus");
    end

    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        break;
      end
      if (op.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);  // Skip comment line
      end else begin
        for (int k = 0; k < 6; k++) begin
          a[k] = 0;
        end
        case (op)
          "beat": begin
            n_exp = 6;
            code  = $fscanf(fd, "%h %h %d %d %d %d", a[0], a[1], a[2], a[3], a[4], a[5]);
          end
          "idle", "clear": begin
            n_exp = 1;
            code  = $fscanf(fd, "%d", a[0]);
          end
          "prst": begin
            n_exp = 2;
            code  = $fscanf(fd, "%d %d", a[0], a[1]);
          end
          "check": begin
            n_exp = 3;
            code  = $fscanf(fd, "%d %d %d", a[0], a[1], a[2]);
          end
          default: begin
            n_exp = 1;
            code  = 0;
          end
        endcase
        assert (code == n_exp) else begin
          $display("Unknown or incomplete command %s in the tests file", op);
          $display("Something failed");
          $fatal(1, "Bad tests file");
        end
        op_q.push_back(op);
        for (int k = 0; k < 6; k++) begin
          arg_q.push_back(a[k]);
        end
        case (op)
          "beat":  total_cycles += a[5];
          "idle":  total_cycles += a[0];
          "check": total_cycles += 8;
          default: total_cycles += 1;
        endcase
      end
    end
    $fclose(fd);

    // Watchdog sized from the command list plus reset and a margin
    fork
      begin
        #((total_cycles + 4 + 200) * 40);
        $display("Simulation timed out before all tests finished");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
      end
    join_none

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    foreach (op_q[i]) begin
      for (int k = 0; k < 6; k++) begin
        a[k] = arg_q[i*6 + k];
      end
      case (op_q[i])
        "beat":  repeat (a[5]) drive_cycle(a[0], a[1], a[2], a[3], a[4], -1);
        "idle":  repeat (a[0]) drive_cycle(0, 0, 0, 0, 0, -1);
        "clear": drive_cycle(0, 0, 0, 0, 0, a[0]);
        "prst": begin
          rst_level[a[0]] = (a[1] != 0);
          drive_cycle(0, 0, 0, 0, 0, -1);
        end
        "check": check_port(a[0], a[1], a[2]);
        default: drive_cycle(0, 0, 0, 0, 0, -1);
      endcase
    end

    $display("Everything OK");
    $finish;
  end

endmodule

//--- tb/stat_tests.txt
# beat <port mask hex> <tkeep hex> <tvalid> <tready> <tlast> <cycles>
# idle <cycles> | clear <port> | prst <port> <level> | check <port> <bytes> <frames>
# Bytes are popcounts of tkeep, frames count beats with tlast
beat 1 ff 1 1 0 3
beat 1 0f 1 1 1 1
beat 1 01 1 1 1 2
beat 2 a5 1 1 1 1
beat 2 03 1 1 0 2
check 0 30 3
check 1 8 1
# No handshake means no count
beat 1 ff 1 0 1 4
beat 1 ff 0 1 1 4
beat 2 ff 0 0 1 2
check 0 30 3
check 1 8 1
# Clear touches only the named port
beat 4 7f 1 1 1 5
beat 8 80 1 1 1 3
check 2 35 5
clear 0
check 0 0 0
check 1 8 1
check 2 35 5
check 3 3 3
beat 1 3c 1 1 1 2
check 0 8 2
# Port reset holds zero and drops traffic
prst 1 1
check 1 0 0
beat 2 ff 1 1 1 6
check 1 0 0
check 2 35 5
prst 1 0
idle 2
check 1 0 0
beat 2 0f 1 1 1 2
check 1 8 2
# All ports busy, read back through both clusters
beat f ff 1 1 0 2
beat 5 0f 1 1 1 3
beat a 01 1 1 1 1
beat f 11 1 1 1 1
check 0 38 6
check 1 27 4
check 2 65 9
check 3 22 5
check 2 65 9
# Long burst past 2^16 bytes
clear 3
beat 8 ff 1 1 0 8200
beat 8 ff 1 1 1 1
check 3 65608 1
check 0 38 6
